/* Makefile */
# Verilator build and run of the performance monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_perfmon
FLIST     ?= csr_perfmon.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

/* csr_perfmon.f */
rtl/perfmon_pkg.sv
rtl/event_decoder.sv
rtl/hpm_counter.sv
rtl/csr_bank.sv
rtl/csr_perfmon.sv
tests/tb_csr_perfmon.sv

/* rtl/csr_bank.sv */
/*
 * Performance monitor CSR bank
 * Req/ack access port, address decode and read mux, plus mcycle,
 * minstret and mcountinhibit
 */
`timescale 1ns/1ps

module csr_bank import perfmon_pkg::*;
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  csr_req,
   input  logic                  csr_write,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  logic [XLEN-1:0]       csr_wdata,
   input  logic                  ev_retired,
   input  logic [EV_SEL_W-1:0]   sel_val [NUM_HPM],
   input  logic [2*XLEN-1:0]     cnt_val [NUM_HPM],
   output logic                  csr_ack,
   output logic [XLEN-1:0]       csr_rdata,
   output logic [NUM_HPM-1:0]    sel_wr,
   output logic [NUM_HPM-1:0]    lo_wr,
   output logic [NUM_HPM-1:0]    hi_wr,
   output logic [XLEN-1:0]       wr_data,
   output logic [NUM_HPM-1:0]    inhibit
);

   bank_state_e         state;
   logic                take;
   logic                wr_en;
   logic [XLEN-1:0]     rd_mux;
   logic [XLEN-1:0]     mcountinhibit;
   logic [2*XLEN-1:0]   mcycle;
   logic [2*XLEN-1:0]   minstret;

   // --------------------
   // Handshake
   // New access only from IDLE with the previous ack already gone
   assign take  = csr_req && (state == IDLE) && !csr_ack;
   assign wr_en = take && csr_write;

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= IDLE;
         csr_ack <= 1'b0;
      end
      else
      begin
         if (take)
            state <= ACKED;
         else if (!csr_req)
            state <= IDLE;
         // Ack trails the state by one edge on both sides
         csr_ack <= (state == ACKED);
      end
   end

   // --------------------
   // Slice write strobes, one address per access
   always_comb
   begin
      for (int i = 0; i < NUM_HPM; i++)
      begin
         sel_wr[i] = wr_en && (csr_addr == CSR_ADDR_W'(CSR_MHPMEVENT3 + i));
         lo_wr[i]  = wr_en && (csr_addr == CSR_ADDR_W'(CSR_MHPMCOUNTER3 + i));
         hi_wr[i]  = wr_en && (csr_addr == CSR_ADDR_W'(CSR_MHPMCOUNTER3H + i));
      end
   end

   assign wr_data = csr_wdata;

   // --------------------
   // Read mux, unmapped addresses return zero
   always_comb
   begin
      rd_mux = '0;
      case (csr_addr)
         CSR_MCOUNTINHIBIT: rd_mux = mcountinhibit;
         CSR_MCYCLE:        rd_mux = mcycle[XLEN-1:0];
         CSR_MCYCLEH:       rd_mux = mcycle[2*XLEN-1:XLEN];
         CSR_MINSTRET:      rd_mux = minstret[XLEN-1:0];
         CSR_MINSTRETH:     rd_mux = minstret[2*XLEN-1:XLEN];
         default:
         begin
            for (int i = 0; i < NUM_HPM; i++)
            begin
               if (csr_addr == CSR_ADDR_W'(CSR_MHPMEVENT3 + i))
                  rd_mux = XLEN'(sel_val[i]);
               if (csr_addr == CSR_ADDR_W'(CSR_MHPMCOUNTER3 + i))
                  rd_mux = cnt_val[i][XLEN-1:0];
               if (csr_addr == CSR_ADDR_W'(CSR_MHPMCOUNTER3H + i))
                  rd_mux = cnt_val[i][2*XLEN-1:XLEN];
            end
         end
      endcase
   end

   // Snapshot taken on the accepting edge, held through the ack
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         csr_rdata <= '0;
      else if (take && !csr_write)
         csr_rdata <= rd_mux;
   end

   // --------------------
   // Counter inhibit, bit 1 hardwired low
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         mcountinhibit <= '0;
      else if (wr_en && (csr_addr == CSR_MCOUNTINHIBIT))
         mcountinhibit <= csr_wdata & INHIBIT_MASK;
   end

   assign inhibit = mcountinhibit[3 +: NUM_HPM];

   // Cycle counter, writes win over the increment
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         mcycle <= '0;
      else if (wr_en && (csr_addr == CSR_MCYCLE))
         mcycle[XLEN-1:0] <= csr_wdata;
      else if (wr_en && (csr_addr == CSR_MCYCLEH))
         mcycle[2*XLEN-1:XLEN] <= csr_wdata;
      else if (!mcountinhibit[0])
         mcycle <= mcycle + 1'b1;
   end

   // Instructions retired, fed by the registered EV_RETIRED bit
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         minstret <= '0;
      else if (wr_en && (csr_addr == CSR_MINSTRET))
         minstret[XLEN-1:0] <= csr_wdata;
      else if (wr_en && (csr_addr == CSR_MINSTRETH))
         minstret[2*XLEN-1:XLEN] <= csr_wdata;
      else if (ev_retired && !mcountinhibit[2])
         minstret <= minstret + 1'b1;
   end

endmodule

/* rtl/csr_perfmon.sv */
/*
 * Machine-mode performance monitor
 * Event decoder feeding the counter slices, drained by the CSR bank
 */
`timescale 1ns/1ps

module csr_perfmon import perfmon_pkg::*;
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   // Retirement side
   input  logic                  ret_valid,
   input  ret_class_e            ret_class,
   input  logic                  exc_valid,
   input  exc_cause_e            exc_cause,
   input  logic                  ext_irq,
   // CSR access port
   input  logic                  csr_req,
   input  logic                  csr_write,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  logic [XLEN-1:0]       csr_wdata,
   output logic                  csr_ack,
   output logic [XLEN-1:0]       csr_rdata
);

   logic [NUM_EVENTS-1:0] ev_vec;
   logic [NUM_HPM-1:0]    sel_wr;
   logic [NUM_HPM-1:0]    lo_wr;
   logic [NUM_HPM-1:0]    hi_wr;
   logic [XLEN-1:0]       wr_data;
   logic [NUM_HPM-1:0]    inhibit;
   logic [EV_SEL_W-1:0]   sel_val [NUM_HPM];
   logic [2*XLEN-1:0]     cnt_val [NUM_HPM];

   // --------------------
   event_decoder u_event_decoder (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .ret_valid (ret_valid),
      .ret_class (ret_class),
      .exc_valid (exc_valid),
      .exc_cause (exc_cause),
      .ext_irq   (ext_irq),
      .ev_vec    (ev_vec)
   );

   // One slice per mhpmcounter3 upward
   for (genvar i = 0; i < NUM_HPM; i++)
   begin : g_hpm
      hpm_counter u_hpm_counter (
         .clk_in  (clk_in),
         .arst_n  (arst_n),
         .ev_vec  (ev_vec),
         .inhibit (inhibit[i]),
         .sel_wr  (sel_wr[i]),
         .lo_wr   (lo_wr[i]),
         .hi_wr   (hi_wr[i]),
         .wr_data (wr_data),
         .sel_val (sel_val[i]),
         .cnt_val (cnt_val[i])
      );
   end

   // minstret taps the decoded retirement bit
   csr_bank u_csr_bank (
      .clk_in     (clk_in),
      .arst_n     (arst_n),
      .csr_req    (csr_req),
      .csr_write  (csr_write),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .ev_retired (ev_vec[EV_RETIRED]),
      .sel_val    (sel_val),
      .cnt_val    (cnt_val),
      .csr_ack    (csr_ack),
      .csr_rdata  (csr_rdata),
      .sel_wr     (sel_wr),
      .lo_wr      (lo_wr),
      .hi_wr      (hi_wr),
      .wr_data    (wr_data),
      .inhibit    (inhibit)
   );

endmodule

/* rtl/event_decoder.sv */
/*
 * Event decoder
 * Turns retirement class, exception and interrupt inputs into a registered
 * one-bit-per-event vector for the counters
 */
`timescale 1ns/1ps

module event_decoder import perfmon_pkg::*;
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  ret_valid,
   input  ret_class_e            ret_class,
   input  logic                  exc_valid,
   input  exc_cause_e            exc_cause,
   input  logic                  ext_irq,
   output logic [NUM_EVENTS-1:0] ev_vec
);

   logic [NUM_EVENTS-1:0] ev_nxt;

   // --------------------
   // Decode for this cycle, EV_NONE never set
   always_comb
   begin
      ev_nxt = '0;
      if (ret_valid)
      begin
         // Any retirement counts, hints and unknowns included
         ev_nxt[EV_RETIRED]   = 1'b1;
         ev_nxt[EV_CTRL_XFER] = (ret_class inside {BRANCH, JAL, JALR});
         case (ret_class)
            LOAD:    ev_nxt[EV_LOAD]   = 1'b1;
            STORE:   ev_nxt[EV_STORE]  = 1'b1;
            CSR:     ev_nxt[EV_CSR]    = 1'b1;
            SYS:     ev_nxt[EV_SYS]    = 1'b1;
            ALU:     ev_nxt[EV_ALU]    = 1'b1;
            BRANCH:  ev_nxt[EV_BRANCH] = 1'b1;
            JAL:     ev_nxt[EV_JAL]    = 1'b1;
            JALR:    ev_nxt[EV_JALR]   = 1'b1;
            MUL:     ev_nxt[EV_MUL]    = 1'b1;
            DIV:     ev_nxt[EV_DIV]    = 1'b1;
            REM:     ev_nxt[EV_REM]    = 1'b1;
            // HINT and UNKNOWN have no class event of their own
            default: ;
         endcase
      end
      if (exc_valid)
      begin
         ev_nxt[EV_ILLEGAL]    = (exc_cause == ILLEGAL);
         // Fetch, load and store misalignment folded together
         ev_nxt[EV_MISALIGNED] =
            (exc_cause inside {INSTR_MISALIGNED, LOAD_MISALIGNED, STORE_MISALIGNED});
      end
      ev_nxt[EV_EXT_IRQ] = ext_irq;
   end

   // One register stage before the slices
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         ev_vec <= '0;
      else
         ev_vec <= ev_nxt;
   end

endmodule

/* rtl/hpm_counter.sv */
/*
 * Hardware performance counter slice
 * One mhpmevent selector plus its 64-bit mhpmcounter
 */
`timescale 1ns/1ps

module hpm_counter import perfmon_pkg::*;
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic [NUM_EVENTS-1:0] ev_vec,
   input  logic                  inhibit,
   input  logic                  sel_wr,
   input  logic                  lo_wr,
   input  logic                  hi_wr,
   input  logic [XLEN-1:0]       wr_data,
   output logic [EV_SEL_W-1:0]   sel_val,
   output logic [2*XLEN-1:0]     cnt_val
);

   // Event vector padded out to every selector code
   logic [(1 << EV_SEL_W)-1:0] ev_ext;
   logic                       hit;

   assign ev_ext = {{((1 << EV_SEL_W) - NUM_EVENTS){1'b0}}, ev_vec};

   // Unused codes and EV_NONE never count
   assign hit = (sel_val != EV_NONE)
             && (sel_val < EV_SEL_W'(NUM_EVENTS))
             && ev_ext[sel_val]
             && !inhibit;

   // --------------------
   // Event selector, low bits of the write only
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         sel_val <= '0;
      else if (sel_wr)
         sel_val <= wr_data[EV_SEL_W-1:0];
   end

   // --------------------
   // Counter
   // A half-word write takes the cycle and the increment is lost
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         cnt_val <= '0;
      else if (lo_wr || hi_wr)
      begin
         if (lo_wr)
            cnt_val[XLEN-1:0] <= wr_data;
         if (hi_wr)
            cnt_val[2*XLEN-1:XLEN] <= wr_data;
      end
      // Full 64-bit add so the low half carries into the high
      else if (hit)
         cnt_val <= cnt_val + 1'b1;
   end

endmodule

/* rtl/perfmon_pkg.sv */
/*
 * Performance monitor shared definitions
 * Widths, CSR addresses, event indices and state encodings
 */
package perfmon_pkg;

   // --------------------
   // Widths
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;
   localparam int NUM_HPM    = 4;
   localparam int EV_SEL_W   = 5;
   localparam int NUM_EVENTS = 17;

   // --------------------
   // CSR addresses
   localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTINHIBIT = 12'h320;
   // Slice n selector sits at this base plus n
   localparam logic [CSR_ADDR_W-1:0] CSR_MHPMEVENT3    = 12'h323;
   localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE        = 12'hB00;
   localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH       = 12'hB80;
   localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET      = 12'hB02;
   localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH     = 12'hB82;
   localparam logic [CSR_ADDR_W-1:0] CSR_MHPMCOUNTER3  = 12'hB03;
   localparam logic [CSR_ADDR_W-1:0] CSR_MHPMCOUNTER3H = 12'hB83;

   // Writable inhibit bits: CY, IR and one per slice (TM stays zero)
   localparam logic [XLEN-1:0] INHIBIT_MASK =
      XLEN'(((1 << NUM_HPM) - 1) << 3) | XLEN'(5);

   // --------------------
   // Retirement class of the instruction leaving the pipe
   typedef enum logic [3:0] {
      LOAD, STORE, CSR, SYS, ALU, BRANCH, JAL, JALR,
      MUL, DIV, REM, HINT, UNKNOWN
   } ret_class_e;

   // Exception causes as encoded in mcause
   typedef enum logic [3:0] {
      INSTR_MISALIGNED = 4'd0,
      INSTR_FAULT      = 4'd1,
      ILLEGAL          = 4'd2,
      BREAKPOINT       = 4'd3,
      LOAD_MISALIGNED  = 4'd4,
      STORE_MISALIGNED = 4'd6,
      ECALL_U          = 4'd8
   } exc_cause_e;

   // Event index, also the value written into mhpmeventN
   typedef enum logic [EV_SEL_W-1:0] {
      EV_NONE       = 5'd0,
      EV_LOAD       = 5'd1,
      EV_STORE      = 5'd2,
      EV_CSR        = 5'd3,
      EV_SYS        = 5'd4,
      EV_ALU        = 5'd5,
      EV_BRANCH     = 5'd6,
      EV_JAL        = 5'd7,
      EV_JALR       = 5'd8,
      EV_MUL        = 5'd9,
      EV_DIV        = 5'd10,
      EV_REM        = 5'd11,
      EV_ILLEGAL    = 5'd12,
      EV_CTRL_XFER  = 5'd13,
      EV_MISALIGNED = 5'd14,
      EV_RETIRED    = 5'd15,
      EV_EXT_IRQ    = 5'd16
   } hpm_event_e;

   // CSR access handshake
   typedef enum logic {
      IDLE,
      ACKED
   } bank_state_e;

endpackage

/* tests/tb_csr_perfmon.sv */
/*
 * Performance monitor testbench
 * Table of CSR accesses and event bursts, checked against a reference model
 */
`timescale 1ns/1ps

module tb_csr_perfmon import perfmon_pkg::*;
();

   localparam int RESET_CYCLES = 3;
   localparam int ROW_CYCLES   = 60;
   localparam int ACK_LIMIT    = 4;

   typedef enum {
      OP_WR, OP_RD, OP_CLEAR, OP_BURST, OP_IRQ, OP_CHECK, OP_HOLD, OP_MCYCLE
   } op_e;

   // One table row, data is write value, expected value or burst length
   typedef struct {
      op_e                   op;
      logic [CSR_ADDR_W-1:0] addr;
      logic [XLEN-1:0]       data;
   } row_t;

   logic                  clk_in;
   logic                  arst_n;
   logic                  ret_valid;
   ret_class_e            ret_class;
   logic                  exc_valid;
   exc_cause_e            exc_cause;
   logic                  ext_irq;
   logic                  csr_req;
   logic                  csr_write;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [XLEN-1:0]       csr_wdata;
   logic                  csr_ack;
   logic [XLEN-1:0]       csr_rdata;

   row_t rows[$];
   bit   table_built;
   int   errors;
   int   cycles;
   int   seed;

   // Reference model state
   logic [XLEN-1:0]     m_inhibit;
   logic [EV_SEL_W-1:0] m_sel [NUM_HPM];
   logic [2*XLEN-1:0]   m_cnt [NUM_HPM];
   logic [2*XLEN-1:0]   m_instret;

   exc_cause_e causes [7] = '{INSTR_MISALIGNED, INSTR_FAULT, ILLEGAL, BREAKPOINT,
                              LOAD_MISALIGNED, STORE_MISALIGNED, ECALL_U};

   csr_perfmon u_dut (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .ret_valid (ret_valid),
      .ret_class (ret_class),
      .exc_valid (exc_valid),
      .exc_cause (exc_cause),
      .ext_irq   (ext_irq),
      .csr_req   (csr_req),
      .csr_write (csr_write),
      .csr_addr  (csr_addr),
      .csr_wdata (csr_wdata),
      .csr_ack   (csr_ack),
      .csr_rdata (csr_rdata)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #4 clk_in = ~clk_in;
   end

   // --------------------
   // Reference model
   function automatic void track_write(input logic [CSR_ADDR_W-1:0] addr,
                                       input logic [XLEN-1:0] data);
      logic [XLEN-1:0] mask;
      // CY, IR and one bit per slice from bit 3 up
      mask    = '0;
      mask[0] = 1'b1;
      mask[2] = 1'b1;
      for (int i = 0; i < NUM_HPM; i++)
         mask[3 + i] = 1'b1;
      if (addr == CSR_MCOUNTINHIBIT)
         m_inhibit = data & mask;
      if (addr == CSR_MINSTRET)
         m_instret[XLEN-1:0] = data;
      if (addr == CSR_MINSTRETH)
         m_instret[2*XLEN-1:XLEN] = data;
      for (int i = 0; i < NUM_HPM; i++)
      begin
         if (addr == CSR_MHPMEVENT3 + CSR_ADDR_W'(i))
            m_sel[i] = data[EV_SEL_W-1:0];
         if (addr == CSR_MHPMCOUNTER3 + CSR_ADDR_W'(i))
            m_cnt[i][XLEN-1:0] = data;
         if (addr == CSR_MHPMCOUNTER3H + CSR_ADDR_W'(i))
            m_cnt[i][2*XLEN-1:XLEN] = data;
      end
   endfunction

   // Unmapped addresses and mcycle read zero here
   function automatic logic [XLEN-1:0] predict_read(input logic [CSR_ADDR_W-1:0] addr);
      logic [XLEN-1:0] val;
      val = '0;
      if (addr == CSR_MCOUNTINHIBIT)
         val = m_inhibit;
      if (addr == CSR_MINSTRET)
         val = m_instret[XLEN-1:0];
      if (addr == CSR_MINSTRETH)
         val = m_instret[2*XLEN-1:XLEN];
      for (int i = 0; i < NUM_HPM; i++)
      begin
         if (addr == CSR_MHPMEVENT3 + CSR_ADDR_W'(i))
            val = XLEN'(m_sel[i]);
         if (addr == CSR_MHPMCOUNTER3 + CSR_ADDR_W'(i))
            val = m_cnt[i][XLEN-1:0];
         if (addr == CSR_MHPMCOUNTER3H + CSR_ADDR_W'(i))
            val = m_cnt[i][2*XLEN-1:XLEN];
      end
      return val;
   endfunction

   function automatic logic [NUM_EVENTS-1:0] decode_events(input logic v,
      input ret_class_e cls, input logic e, input exc_cause_e cause, input logic irq);
      logic [NUM_EVENTS-1:0] ev;
      ev = '0;
      if (v)
      begin
         ev[EV_RETIRED] = 1'b1;
         // Classes LOAD to REM map onto indices 1 to 11
         if (cls <= REM)
            ev[int'(cls) + 1] = 1'b1;
         if (cls == BRANCH || cls == JAL || cls == JALR)
            ev[EV_CTRL_XFER] = 1'b1;
      end
      if (e && cause == ILLEGAL)
         ev[EV_ILLEGAL] = 1'b1;
      if (e && (cause == INSTR_MISALIGNED || cause == LOAD_MISALIGNED
                || cause == STORE_MISALIGNED))
         ev[EV_MISALIGNED] = 1'b1;
      ev[EV_EXT_IRQ] = irq;
      return ev;
   endfunction

   // One cycle of events applied to every modeled counter
   function automatic void apply_events(input logic [NUM_EVENTS-1:0] ev, input logic v);
      logic [31:0] evx;
      evx = 32'(ev);
      for (int i = 0; i < NUM_HPM; i++)
      begin
         if (m_sel[i] != '0 && int'(m_sel[i]) < NUM_EVENTS && evx[m_sel[i]]
             && !m_inhibit[3 + i])
            m_cnt[i] = m_cnt[i] + 64'd1;
      end
      if (v && !m_inhibit[2])
         m_instret = m_instret + 64'd1;
   endfunction

   // --------------------
   // Bus and stimulus tasks
   task automatic check_value(input logic [CSR_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] got);
      assert (got === exp)
      else
      begin
         $display("** Error at %0t: addr %h expected %h got %h", $time, addr, exp, got);
         errors++;
      end
   endtask

   // Full four-phase access, req held for extra cycles when hold is set
   task automatic csr_access(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
      input logic [XLEN-1:0] wdata, input int hold, output logic [XLEN-1:0] rdata);
      int n;
      @(posedge clk_in);
      csr_req   <= 1'b1;
      csr_write <= wr;
      csr_addr  <= addr;
      csr_wdata <= wdata;
      n = 0;
      @(negedge clk_in);
      while (!csr_ack && n < ACK_LIMIT)
      begin
         @(negedge clk_in);
         n++;
      end
      if (!csr_ack)
      begin
         $display("CSR access to %h got no ack within %0d cycles", addr, ACK_LIMIT);
         errors++;
      end
      rdata = csr_rdata;
      repeat (hold)
      begin
         @(negedge clk_in);
         assert (csr_ack === 1'b1)
         else
         begin
            $display("** Error at %0t: ack dropped with req held, addr %h", $time, addr);
            errors++;
         end
      end
      @(posedge clk_in);
      csr_req <= 1'b0;
      @(negedge clk_in);
      n = 0;
      while (csr_ack && n < 6)
      begin
         @(negedge clk_in);
         n++;
      end
      assert (n <= 2)
      else
      begin
         $display("** Error at %0t: ack fell %0d cycles after req, addr %h", $time, n, addr);
         errors++;
      end
   endtask

   task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
      logic [XLEN-1:0] rd;
      csr_access(1'b1, addr, data, 0, rd);
      track_write(addr, data);
   endtask

   task automatic read_and_compare(input logic [CSR_ADDR_W-1:0] addr);
      logic [XLEN-1:0] rd;
      csr_access(1'b0, addr, '0, 0, rd);
      check_value(addr, predict_read(addr), rd);
   endtask

   task automatic clear_counters();
      for (int i = 0; i < NUM_HPM; i++)
      begin
         write_csr(CSR_MHPMCOUNTER3 + CSR_ADDR_W'(i), '0);
         write_csr(CSR_MHPMCOUNTER3H + CSR_ADDR_W'(i), '0);
      end
      write_csr(CSR_MINSTRET, '0);
      write_csr(CSR_MINSTRETH, '0);
   endtask

   // Selectors, both counter halves of each slice, minstret and inhibit
   task automatic check_model();
      for (int i = 0; i < NUM_HPM; i++)
      begin
         read_and_compare(CSR_MHPMEVENT3 + CSR_ADDR_W'(i));
         read_and_compare(CSR_MHPMCOUNTER3 + CSR_ADDR_W'(i));
         read_and_compare(CSR_MHPMCOUNTER3H + CSR_ADDR_W'(i));
      end
      read_and_compare(CSR_MINSTRET);
      read_and_compare(CSR_MINSTRETH);
      read_and_compare(CSR_MCOUNTINHIBIT);
   endtask

   // Random retirement traffic, or interrupt pulses only
   task automatic run_burst(input int len, input bit irq_only);
      logic [31:0] r;
      logic        v;
      ret_class_e  cls;
      logic        e;
      exc_cause_e  cause;
      logic        irq;
      for (int k = 0; k < len; k++)
      begin
         r     = $random(seed);
         v     = !irq_only && (r[1:0] != 2'b00);
         cls   = ret_class_e'(4'(int'(r[15:8]) % 13));
         e     = !irq_only && (r[18:17] == 2'b00);
         cause = causes[int'(r[27:20]) % 7];
         irq   = irq_only || r[30];
         @(posedge clk_in);
         ret_valid <= v;
         ret_class <= cls;
         exc_valid <= e;
         exc_cause <= cause;
         ext_irq   <= irq;
         apply_events(decode_events(v, cls, e, cause, irq), v);
      end
      @(posedge clk_in);
      ret_valid <= 1'b0;
      exc_valid <= 1'b0;
      ext_irq   <= 1'b0;
      // Decoder stage and counter stage, plus one spare
      repeat (3) @(posedge clk_in);
   endtask

   // --------------------
   // Test table
   function automatic void add_row(input op_e op, input logic [CSR_ADDR_W-1:0] addr,
                                   input logic [XLEN-1:0] data);
      row_t row;
      row.op   = op;
      row.addr = addr;
      row.data = data;
      rows.push_back(row);
   endfunction

   function automatic void build_table();
      // Reset values
      add_row(OP_RD, CSR_MCOUNTINHIBIT, '0);
      for (int i = 0; i < NUM_HPM; i++)
      begin
         add_row(OP_RD, CSR_MHPMEVENT3 + CSR_ADDR_W'(i), '0);
         add_row(OP_RD, CSR_MHPMCOUNTER3 + CSR_ADDR_W'(i), '0);
         add_row(OP_RD, CSR_MHPMCOUNTER3H + CSR_ADDR_W'(i), '0);
      end
      // Register read back, selectors keep five bits, inhibit bit 1 stays low
      add_row(OP_WR, CSR_MHPMEVENT3, 32'hFFFF_FFE5);
      add_row(OP_RD, CSR_MHPMEVENT3, 32'h0000_0005);
      add_row(OP_WR, CSR_MHPMCOUNTER3 + 12'd1, 32'h1234_5678);
      add_row(OP_RD, CSR_MHPMCOUNTER3 + 12'd1, 32'h1234_5678);
      add_row(OP_WR, CSR_MHPMCOUNTER3H + 12'd1, 32'h9ABC_DEF0);
      add_row(OP_RD, CSR_MHPMCOUNTER3H + 12'd1, 32'h9ABC_DEF0);
      add_row(OP_WR, CSR_MINSTRETH, 32'h0000_00A5);
      add_row(OP_RD, CSR_MINSTRETH, 32'h0000_00A5);
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
      add_row(OP_RD, CSR_MCOUNTINHIBIT, 32'h0000_007D);
      add_row(OP_WR, 12'h7C0, 32'hDEAD_BEEF);
      add_row(OP_RD, 12'h7C0, '0);
      // Event counting from a cleared state
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_007D);
      add_row(OP_CLEAR, '0, '0);
      add_row(OP_WR, CSR_MHPMEVENT3, XLEN'(EV_LOAD));
      add_row(OP_WR, CSR_MHPMEVENT3 + 12'd1, XLEN'(EV_CTRL_XFER));
      add_row(OP_WR, CSR_MHPMEVENT3 + 12'd2, XLEN'(EV_MISALIGNED));
      add_row(OP_WR, CSR_MHPMEVENT3 + 12'd3, XLEN'(EV_RETIRED));
      add_row(OP_WR, CSR_MCOUNTINHIBIT, '0);
      add_row(OP_BURST, '0, 32'd48);
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_007D);
      add_row(OP_CHECK, '0, '0);
      // minstret and slice 2 held while the rest count
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_0024);
      add_row(OP_BURST, '0, 32'd48);
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_007D);
      add_row(OP_CHECK, '0, '0);
      // Low half wraps into the high half
      add_row(OP_WR, CSR_MHPMEVENT3, XLEN'(EV_EXT_IRQ));
      add_row(OP_WR, CSR_MHPMCOUNTER3, 32'hFFFF_FFFF);
      add_row(OP_WR, CSR_MHPMCOUNTER3H, '0);
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_0074);
      add_row(OP_IRQ, '0, 32'd1);
      add_row(OP_WR, CSR_MCOUNTINHIBIT, 32'h0000_007D);
      add_row(OP_RD, CSR_MHPMCOUNTER3, '0);
      add_row(OP_RD, CSR_MHPMCOUNTER3H, 32'h0000_0001);
      add_row(OP_CHECK, '0, '0);
      // Held request and a free-running mcycle
      add_row(OP_WR, CSR_MCOUNTINHIBIT, '0);
      add_row(OP_HOLD, CSR_MCOUNTINHIBIT, '0);
      add_row(OP_MCYCLE, CSR_MCYCLE, '0);
   endfunction

   // --------------------
   // Main sequence
   initial
   begin
      logic [XLEN-1:0] rd;
      logic [XLEN-1:0] first;
      seed      = 22;
      errors    = 0;
      arst_n    = 1'b0;
      ret_valid = 1'b0;
      ret_class = LOAD;
      exc_valid = 1'b0;
      exc_cause = INSTR_MISALIGNED;
      ext_irq   = 1'b0;
      csr_req   = 1'b0;
      csr_write = 1'b0;
      csr_addr  = '0;
      csr_wdata = '0;
      m_inhibit = '0;
      m_instret = '0;
      for (int i = 0; i < NUM_HPM; i++)
      begin
         m_sel[i] = '0;
         m_cnt[i] = '0;
      end
      build_table();
      table_built = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_in);
      arst_n <= 1'b1;
      @(negedge clk_in);
      assert (csr_ack === 1'b0)
      else
      begin
         $display("** Error at %0t: csr_ack high after reset", $time);
         errors++;
      end
      foreach (rows[r])
      begin
         case (rows[r].op)
            OP_WR:     write_csr(rows[r].addr, rows[r].data);
            OP_RD:
            begin
               csr_access(1'b0, rows[r].addr, '0, 0, rd);
               check_value(rows[r].addr, rows[r].data, rd);
            end
            OP_CLEAR:  clear_counters();
            OP_BURST:  run_burst(int'(rows[r].data), 1'b0);
            OP_IRQ:    run_burst(int'(rows[r].data), 1'b1);
            OP_CHECK:  check_model();
            OP_HOLD:
            begin
               csr_access(1'b0, rows[r].addr, '0, 5, rd);
               check_value(rows[r].addr, rows[r].data, rd);
            end
            OP_MCYCLE:
            begin
               csr_access(1'b0, rows[r].addr, '0, 0, first);
               csr_access(1'b0, rows[r].addr, '0, 0, rd);
               assert (rd > first)
               else
               begin
                  $display("** Error at %0t: mcycle went from %h to %h", $time, first, rd);
                  errors++;
               end
            end
            default: ;
         endcase
      end
      $display("Run complete with %0d errors over %0d rows", errors, rows.size());
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   // Watchdog sized from the table length
   initial
   begin
      cycles = 0;
      wait (table_built);
      while (cycles < ROW_CYCLES * rows.size() + RESET_CYCLES)
      begin
         @(posedge clk_in);
         cycles++;
      end
      $display("Timeout, run stopped after %0d clock cycles", cycles);
      $display("Finished with errors");
      $finish;
   end

endmodule
